/* common/lcd_config.svh */
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// Bus timing in clk cycles
`define LCD_SETUP 1
`define LCD_E_HIGH 4
`define LCD_HOLD 1
`define LCD_BUS_CYCLES (`LCD_SETUP + `LCD_E_HIGH + `LCD_HOLD)

// Status reads allowed per byte before moving on
`define LCD_BUSY_POLL_MAX 4096

// Display geometry
`define LCD_COLS 16

// Set DDRAM address commands for the start of each row
`define LCD_ROW1_ADDR 8'h80
`define LCD_ROW2_ADDR 8'hC0

`endif

/* common/lcd_pkg.sv */
package lcd_pkg;

  // Sixteen hex digits with digit 0 in bits 63:60
  typedef logic [63:0] row_data_t;

  // One enable per column with bit 15 for column 0
  typedef logic [15:0] row_mask_t;

  // Display column from 0 to 15
  typedef logic [3:0] col_idx_t;

  // Value on the 4-bit data bus
  typedef logic [3:0] nibble_t;

  // Character code or command byte
  typedef logic [7:0] lcd_char_t;

  // Sequencer states
  // SEND_CMD carries any byte out as two nibbles while WAIT_BUSY polls the status
  // and the others pick the next byte to send
  typedef enum logic [2:0] {
    IDLE,
    INIT_MODE4,
    SEND_CMD,
    WAIT_BUSY,
    ROW1,
    ROW2_ADDR,
    ROW2,
    ACK
  } seq_state_t;

endpackage

/* hdl/hex_row_formatter.sv */
`timescale 1ns/100ps

module hex_row_formatter import lcd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      load,
  input  row_data_t data,
  input  row_mask_t mask,
  input  col_idx_t  col,
  output lcd_char_t ch
);

  row_data_t data_q;
  row_mask_t mask_q;
  nibble_t   digit;
  logic      enabled;

  // Hex digit to its ASCII code
  function automatic lcd_char_t hex_ascii(input nibble_t d);
    if (d < 4'd10) begin
      hex_ascii = 8'h30 + {4'h0, d};
    end else begin
      hex_ascii = 8'h37 + {4'h0, d};
    end
  endfunction

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= data;
    end
  end

  // Blank row until the first load
  always_ff @(posedge clk) begin
    if (rst) begin
      mask_q <= '0;
    end else if (load) begin
      mask_q <= mask;
    end
  end

  // Column 0 sits at the top, so flip the index
  assign digit   = data_q[{~col, 2'b00} +: 4];
  assign enabled = mask_q[~col];

  assign ch = enabled ? hex_ascii(digit) : 8'h20;

endmodule

/* lcd_bus/lcd_nibble_bus.sv */
`timescale 1ns/100ps
`include "lcd_config.svh"

module lcd_nibble_bus import lcd_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    rs,
  input  logic    rw,
  input  nibble_t wr_nibble,
  input  nibble_t lcd_db_in,
  output logic    done,
  output nibble_t rd_nibble,
  output logic    lcd_rs,
  output logic    lcd_rw,
  output logic    lcd_e,
  output nibble_t lcd_db_out,
  output logic    lcd_db_oe
);

  logic       active;
  logic [7:0] phase;
  logic [7:0] phase_nxt;
  logic       e_nxt;
  logic       e_last;

  // Phase the engine will be in after this edge
  assign phase_nxt = active ? phase + 8'd1 : 8'd0;

  // Enable window follows the setup phases
  assign e_nxt = (phase_nxt >= 8'(`LCD_SETUP)) &&
                 (phase_nxt < 8'(`LCD_SETUP + `LCD_E_HIGH));

  assign e_last = active && (phase == 8'(`LCD_SETUP + `LCD_E_HIGH - 1));

  // Done marks the last hold cycle
  assign done = active && (phase == 8'(`LCD_BUS_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      phase     <= 8'd0;
      lcd_e     <= 1'b0;
      lcd_db_oe <= 1'b0;
      lcd_rs    <= 1'b0;
      lcd_rw    <= 1'b1;
    end else if (done) begin
      active    <= 1'b0;
      phase     <= 8'd0;
      lcd_e     <= 1'b0;
      lcd_db_oe <= 1'b0;
    end else if (active) begin
      phase <= phase_nxt;
      lcd_e <= e_nxt;
    end else if (start) begin
      // rs and rw stay put until the next start
      active    <= 1'b1;
      phase     <= 8'd0;
      lcd_e     <= e_nxt;
      lcd_rs    <= rs;
      lcd_rw    <= rw;
      lcd_db_oe <= ~rw;
    end
  end

  // Write data held for the whole cycle
  always_ff @(posedge clk) begin
    if (start && !active) begin
      lcd_db_out <= wr_nibble;
    end
  end

  // Panel data is sampled at the end of the enable pulse
  always_ff @(posedge clk) begin
    if (e_last && lcd_rw) begin
      rd_nibble <= lcd_db_in;
    end
  end

endmodule

/* lcd_bus/lcd_sequencer.sv */
`timescale 1ns/100ps
`include "lcd_config.svh"

module lcd_sequencer import lcd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      update_req,
  input  lcd_char_t ch1,
  input  lcd_char_t ch2,
  input  logic      bus_done,
  input  nibble_t   bus_rd,
  output logic      update_ack,
  output logic      fmt_load,
  output col_idx_t  col,
  output logic      bus_start,
  output logic      bus_rs,
  output logic      bus_rw,
  output nibble_t   bus_wr
);

  seq_state_t  state;
  seq_state_t  ret_state;
  lcd_char_t   byte_q;
  logic        nib_hi;
  logic        stat_first;
  logic        busy_q;
  logic [12:0] poll_cnt;
  logic [2:0]  init_idx;
  logic        init_done;

  logic        disp_go;
  lcd_char_t   disp_byte;
  logic        disp_rs;
  seq_state_t  disp_ret;
  logic        last_col;

  function automatic lcd_char_t init_cmd(input logic [2:0] idx);
    case (idx)
      3'd0:    init_cmd = 8'h28;  // 4-bit bus, two lines, 5x8 font
      3'd1:    init_cmd = 8'h0C;  // Display on, cursor off
      3'd2:    init_cmd = 8'h01;  // Clear display
      default: init_cmd = 8'h06;  // Address increment, no shift
    endcase
  endfunction

  assign last_col = (col == col_idx_t'(`LCD_COLS - 1));

  // Next byte to send from the dispatch states
  always_comb begin
    disp_go   = 1'b0;
    disp_byte = `LCD_ROW1_ADDR;
    disp_rs   = 1'b0;
    disp_ret  = ROW1;
    case (state)
      IDLE: begin
        disp_go = update_req && init_done;
      end
      INIT_MODE4: begin
        disp_go = 1'b1;
        if (init_idx != 3'd4) begin
          disp_byte = init_cmd(init_idx);
          disp_ret  = INIT_MODE4;
        end
      end
      ROW1: begin
        disp_go   = 1'b1;
        disp_byte = ch1;
        disp_rs   = 1'b1;
        disp_ret  = last_col ? ROW2_ADDR : ROW1;
      end
      ROW2_ADDR: begin
        disp_go   = 1'b1;
        disp_byte = `LCD_ROW2_ADDR;
        disp_ret  = ROW2;
      end
      ROW2: begin
        disp_go   = 1'b1;
        disp_byte = ch2;
        disp_rs   = 1'b1;
        disp_ret  = last_col ? ACK : ROW2;
      end
      default: begin
        disp_go = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      ret_state  <= IDLE;
      nib_hi     <= 1'b0;
      stat_first <= 1'b0;
      busy_q     <= 1'b0;
      poll_cnt   <= '0;
      init_idx   <= '0;
      init_done  <= 1'b0;
      col        <= '0;
      fmt_load   <= 1'b0;
      update_ack <= 1'b0;
      bus_start  <= 1'b0;
      bus_rs     <= 1'b0;
      bus_rw     <= 1'b1;
    end else begin
      bus_start <= 1'b0;
      fmt_load  <= 1'b0;
      if (disp_go) begin
        bus_start <= 1'b1;
        bus_rs    <= disp_rs;
        bus_rw    <= 1'b0;
        nib_hi    <= 1'b1;
        ret_state <= disp_ret;
        state     <= SEND_CMD;
      end
      case (state)
        IDLE: begin
          if (update_req) begin
            fmt_load <= 1'b1;
            col      <= '0;
            if (!init_done) begin
              // Lone nibble puts the controller in 4-bit mode
              bus_start <= 1'b1;
              bus_rs    <= 1'b0;
              bus_rw    <= 1'b0;
              nib_hi    <= 1'b0;
              init_idx  <= '0;
              ret_state <= INIT_MODE4;
              state     <= SEND_CMD;
            end
          end
        end
        INIT_MODE4: begin
          if (init_idx != 3'd4) begin
            init_idx <= init_idx + 3'd1;
          end else begin
            init_done <= 1'b1;
          end
        end
        ROW1, ROW2: begin
          col <= col + 4'd1;
        end
        SEND_CMD: begin
          if (bus_done) begin
            bus_start <= 1'b1;
            if (nib_hi) begin
              nib_hi <= 1'b0;
            end else begin
              // Byte finished so read the status
              bus_rs     <= 1'b0;
              bus_rw     <= 1'b1;
              stat_first <= 1'b1;
              poll_cnt   <= '0;
              state      <= WAIT_BUSY;
            end
          end
        end
        WAIT_BUSY: begin
          if (bus_done) begin
            if (stat_first) begin
              stat_first <= 1'b0;
              busy_q     <= bus_rd[3];
              bus_start  <= 1'b1;
            end else if (busy_q && poll_cnt != 13'(`LCD_BUSY_POLL_MAX - 1)) begin
              poll_cnt   <= poll_cnt + 13'd1;
              stat_first <= 1'b1;
              bus_start  <= 1'b1;
            end else begin
              state <= ret_state;
              if (ret_state == ACK) begin
                update_ack <= 1'b1;
              end
            end
          end
        end
        ACK: begin
          if (!update_req) begin
            update_ack <= 1'b0;
            state      <= IDLE;
          end
        end
        default: begin
          // ROW2_ADDR leaves through the dispatch above
        end
      endcase
    end
  end

  // Byte and nibble payload
  always_ff @(posedge clk) begin
    if (disp_go) begin
      byte_q <= disp_byte;
      bus_wr <= disp_byte[7:4];
    end else if (state == IDLE && update_req) begin
      bus_wr <= 4'h2;
    end else if (state == SEND_CMD && bus_done && nib_hi) begin
      bus_wr <= byte_q[3:0];
    end
  end

endmodule

/* hdl/lcd_display.sv */
`timescale 1ns/100ps

module lcd_display import lcd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      update_req,
  input  row_data_t row1,
  input  row_data_t row2,
  input  row_mask_t mask1,
  input  row_mask_t mask2,
  input  nibble_t   lcd_db_in,
  output logic      update_ack,
  output logic      lcd_rs,
  output logic      lcd_rw,
  output logic      lcd_e,
  output nibble_t   lcd_db_out,
  output logic      lcd_db_oe
);

  logic      fmt_load;
  col_idx_t  col;
  lcd_char_t ch1;
  lcd_char_t ch2;
  logic      bus_start;
  logic      bus_rs;
  logic      bus_rw;
  nibble_t   bus_wr;
  logic      bus_done;
  nibble_t   bus_rd;

  // One formatter per display row
  hex_row_formatter row1_fmt (
    .clk  (clk),
    .rst  (rst),
    .load (fmt_load),
    .data (row1),
    .mask (mask1),
    .col  (col),
    .ch   (ch1)
  );

  hex_row_formatter row2_fmt (
    .clk  (clk),
    .rst  (rst),
    .load (fmt_load),
    .data (row2),
    .mask (mask2),
    .col  (col),
    .ch   (ch2)
  );

  lcd_sequencer lcd_sequencer_inst (
    .clk        (clk),
    .rst        (rst),
    .update_req (update_req),
    .ch1        (ch1),
    .ch2        (ch2),
    .bus_done   (bus_done),
    .bus_rd     (bus_rd),
    .update_ack (update_ack),
    .fmt_load   (fmt_load),
    .col        (col),
    .bus_start  (bus_start),
    .bus_rs     (bus_rs),
    .bus_rw     (bus_rw),
    .bus_wr     (bus_wr)
  );

  lcd_nibble_bus lcd_nibble_bus_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (bus_start),
    .rs         (bus_rs),
    .rw         (bus_rw),
    .wr_nibble  (bus_wr),
    .lcd_db_in  (lcd_db_in),
    .done       (bus_done),
    .rd_nibble  (bus_rd),
    .lcd_rs     (lcd_rs),
    .lcd_rw     (lcd_rw),
    .lcd_e      (lcd_e),
    .lcd_db_out (lcd_db_out),
    .lcd_db_oe  (lcd_db_oe)
  );

endmodule

/* tb/lcd_panel_model.sv */
`timescale 1ns/100ps

module lcd_panel_model import lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       lcd_rs,
  input  logic       lcd_rw,
  input  logic       lcd_e,
  input  nibble_t    lcd_db_out,
  input  logic       lcd_db_oe,
  input  logic [4:0] busy_len,
  output nibble_t    lcd_db_in,
  output logic       violation,
  output logic [15:0] data_count,
  output logic [7:0]  log_count
);

  // Command history and the two visible rows with the second row at index 16
  lcd_char_t cmd_log [0:63];
  lcd_char_t ddram [0:31];

  logic [6:0] ac;
  logic [4:0] busy_cnt;
  logic       busy;
  logic       e_q;
  logic       mode4;
  logic       have_hi;
  logic       rd_lo;
  nibble_t    hi_nib;

  assign busy = (busy_cnt != 5'd0);

  // Status read returns busy and the address counter with the high nibble first
  assign lcd_db_in = (lcd_rw && !lcd_rs) ? (rd_lo ? ac[3:0] : {busy, ac[6:4]}) : 4'h0;

  task accept_byte(input logic rs, input lcd_char_t b);
    busy_cnt <= busy_len;
    if (!rs) begin
      if (log_count < 8'd64) begin
        cmd_log[log_count[5:0]] <= b;
      end
      log_count <= log_count + 8'd1;
      if (b[7]) begin
        ac <= b[6:0];
      end else if (b == 8'h01) begin
        for (int i = 0; i < 32; i++) begin
          ddram[i] <= 8'h20;
        end
        ac <= 7'd0;
      end else if (b[7:5] == 3'b001) begin
        // Function set DL bit picks the bus width
        mode4 <= ~b[4];
      end
    end else begin
      if (ac < 7'h10) begin
        ddram[{1'b0, ac[3:0]}] <= b;
      end else if (ac >= 7'h40 && ac < 7'h50) begin
        ddram[{1'b1, ac[3:0]}] <= b;
      end
      ac         <= ac + 7'd1;
      data_count <= data_count + 16'd1;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      e_q        <= 1'b0;
      mode4      <= 1'b0;
      have_hi    <= 1'b0;
      rd_lo      <= 1'b0;
      ac         <= 7'd0;
      busy_cnt   <= 5'd0;
      violation  <= 1'b0;
      data_count <= 16'd0;
      log_count  <= 8'd0;
    end else begin
      e_q <= lcd_e;
      if (busy_cnt != 5'd0) begin
        busy_cnt <= busy_cnt - 5'd1;
      end
      // Write pulse while busy or with the bus not driven
      if (lcd_e && !e_q && !lcd_rw && (busy || !lcd_db_oe)) begin
        violation <= 1'b1;
      end
      if (e_q && !lcd_e) begin
        if (lcd_rw) begin
          rd_lo <= ~rd_lo;
        end else if (!mode4) begin
          // 8-bit mode sees the lone nibble as a whole command
          accept_byte(lcd_rs, {lcd_db_out, 4'h0});
        end else if (!have_hi) begin
          hi_nib  <= lcd_db_out;
          have_hi <= 1'b1;
        end else begin
          have_hi <= 1'b0;
          accept_byte(lcd_rs, {hi_nib, lcd_db_out});
        end
      end
    end
  end

endmodule

/* tb/tb_lcd_display.sv */
`timescale 1ns/100ps
`include "lcd_config.svh"

module tb_lcd_display import lcd_pkg::*; ();

  localparam logic [127:0] hex_table = "0123456789ABCDEF";

  logic       clk;
  logic       rst;
  logic       update_req;
  row_data_t  row1;
  row_data_t  row2;
  row_mask_t  mask1;
  row_mask_t  mask2;
  nibble_t    lcd_db_in;
  logic       update_ack;
  logic       lcd_rs;
  logic       lcd_rw;
  logic       lcd_e;
  nibble_t    lcd_db_out;
  logic       lcd_db_oe;
  logic       violation;
  logic [15:0] data_count;
  logic [7:0]  log_count;
  logic [4:0]  busy_len = 5'd0;
  logic [31:0] busy_rng = 32'd30634 ^ 32'hffff_ffff;
  logic [31:0] frame_rng;
  int          e_run = 0;
  logic        held_rs;
  logic        held_rw;

  lcd_display lcd_display_inst (
    .clk        (clk),
    .rst        (rst),
    .update_req (update_req),
    .row1       (row1),
    .row2       (row2),
    .mask1      (mask1),
    .mask2      (mask2),
    .lcd_db_in  (lcd_db_in),
    .update_ack (update_ack),
    .lcd_rs     (lcd_rs),
    .lcd_rw     (lcd_rw),
    .lcd_e      (lcd_e),
    .lcd_db_out (lcd_db_out),
    .lcd_db_oe  (lcd_db_oe)
  );

  lcd_panel_model panel_inst (
    .clk        (clk),
    .rst        (rst),
    .lcd_rs     (lcd_rs),
    .lcd_rw     (lcd_rw),
    .lcd_e      (lcd_e),
    .lcd_db_out (lcd_db_out),
    .lcd_db_oe  (lcd_db_oe),
    .busy_len   (busy_len),
    .lcd_db_in  (lcd_db_in),
    .violation  (violation),
    .data_count (data_count),
    .log_count  (log_count)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    lcg_step = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Column c shows nibble c from the top or a space when masked off
  function automatic lcd_char_t expected_char(input row_data_t row, input row_mask_t mask,
                                              input int c);
    nibble_t d;
    d = row[63 - 4 * c -: 4];
    if (!mask[15 - c]) begin
      expected_char = 8'h20;
    end else begin
      expected_char = hex_table[8 * (15 - int'(d)) +: 8];
    end
  endfunction

  function automatic lcd_char_t init_command(input int i);
    case (i)
      0:       init_command = 8'h20;
      1:       init_command = 8'h28;
      2:       init_command = 8'h0C;
      3:       init_command = 8'h01;
      default: init_command = 8'h06;
    endcase
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_for_ack(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (update_ack !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (update_ack !== level) begin
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
      $display("TEST FAILED");
      $fatal(1, "handshake timeout");
    end
  endtask

  task automatic draw_word(output logic [15:0] w);
    frame_rng = lcg_step(frame_rng);
    w = frame_rng[31:16];
  endtask

  task automatic check_screen();
    for (int c = 0; c < 16; c++) begin
      check_equal(64'(panel_inst.ddram[c]), 64'(expected_char(row1, mask1, c)),
                  $sformatf("row 1 column %0d", c));
      check_equal(64'(panel_inst.ddram[16 + c]), 64'(expected_char(row2, mask2, c)),
                  $sformatf("row 2 column %0d", c));
    end
  endtask

  task automatic run_frame(input int f);
    logic [15:0] w [0:7];
    logic [15:0] start_count;
    logic [15:0] hold;
    for (int i = 0; i < 8; i++) begin
      draw_word(w[i]);
    end
    draw_word(hold);
    start_count = data_count;
    row1 = {w[0], w[1], w[2], w[3]};
    row2 = {w[4], w[5], w[6], w[7]};
    // First two frames show every digit
    if (f < 2) begin
      mask1 = 16'hffff;
      mask2 = 16'hffff;
    end else begin
      draw_word(mask1);
      draw_word(mask2);
    end
    update_req = 1'b1;
    wait_for_ack(1'b1, 16 * `LCD_BUSY_POLL_MAX, "update_ack rising");
    check_equal(64'(data_count - start_count), 64'd32, "characters written before update_ack");
    check_screen();
    for (int i = 0; i < int'(hold[1:0]); i++) begin
      @(negedge clk);
      check_equal(64'(update_ack), 64'd1, "update_ack held while update_req high");
    end
    update_req = 1'b0;
    wait_for_ack(1'b0, 8, "update_ack falling");
  endtask

  // New busy length each cycle for the panel to pick up
  always @(negedge clk) begin
    busy_rng = lcg_step(busy_rng);
    busy_len <= 5'((busy_rng >> 16) % 32'd21);
  end

  // Bus discipline and busy violations
  always @(negedge clk) begin
    if (!rst) begin
      check_equal(64'(violation), 64'd0, "bus write while panel busy or undriven");
      check_equal(64'(lcd_db_oe & lcd_rw), 64'd0, "lcd_db_oe high during a read");
      if (lcd_e) begin
        if (e_run == 0) begin
          held_rs = lcd_rs;
          held_rw = lcd_rw;
        end else begin
          check_equal(64'(lcd_rs), 64'(held_rs), "lcd_rs changed while lcd_e high");
          check_equal(64'(lcd_rw), 64'(held_rw), "lcd_rw changed while lcd_e high");
        end
        e_run++;
      end else if (e_run != 0) begin
        check_equal(64'(e_run), 64'(`LCD_E_HIGH), "lcd_e pulse width");
        e_run = 0;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    update_req = 1'b0;
    row1       = '0;
    row2       = '0;
    mask1      = '0;
    mask2      = '0;
    frame_rng  = 32'd30634;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_equal(64'(update_ack), 64'd0, "update_ack after reset");
    for (int f = 0; f < 20; f++) begin
      run_frame(f);
      if (f == 0) begin
        check_equal(64'(log_count), 64'd7, "commands after the first frame");
        for (int i = 0; i < 5; i++) begin
          check_equal(64'(panel_inst.cmd_log[i]), 64'(init_command(i)),
                      $sformatf("init command %0d", i));
        end
      end
    end
    // Only row addresses follow the init sequence
    check_equal(64'(log_count), 64'd45, "commands after all frames");
    for (int i = 5; i < 45; i++) begin
      check_equal(64'(panel_inst.cmd_log[i]), (i % 2 == 1) ? 64'h80 : 64'hC0,
                  $sformatf("row address command %0d", i));
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/lcd_pkg.sv
hdl/hex_row_formatter.sv
lcd_bus/lcd_nibble_bus.sv
lcd_bus/lcd_sequencer.sv
hdl/lcd_display.sv
tb/lcd_panel_model.sv
tb/tb_lcd_display.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status gives pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f vlog.f \
  --top-module tb_lcd_display \
  --Mdir obj_dir \
  -o tb_lcd_display

./obj_dir/tb_lcd_display
